//--- hw/axiLitePkg.sv
package axiLitePkg;

  //////////////////////////////////////////////////////////////////////
  // bus field widths
  //////////////////////////////////////////////////////////////////////

  // byte address
  typedef logic [31:0] addrT;
  // register and bus data
  typedef logic [31:0] dataT;
  // one strobe bit per data byte
  typedef logic [3:0] strbT;
  // protection bits travel on the bus only
  typedef logic [2:0] protT;
  // response code on B and R
  typedef logic [1:0] respT;
  // word index into the bank, so at most 256 words
  typedef logic [7:0] regIdxT;

  // response codes used by the bank
  localparam respT RespOkay = 2'b00;
  localparam respT RespSlvErr = 2'b10;

  //////////////////////////////////////////////////////////////////////
  // internal links between decode, execute and result
  //////////////////////////////////////////////////////////////////////

  // accepted write pair
  typedef struct packed {
    regIdxT idx;
    dataT data;
    strbT strb;
    logic err;
  } wrReqT;

  // accepted read
  typedef struct packed {
    regIdxT idx;
    logic err;
  } rdReqT;

  // write completed in the array
  typedef struct packed {
    logic err;
  } wrDoneT;

  // read sampled from the array
  typedef struct packed {
    dataT data;
    logic err;
  } rdDoneT;

endpackage

//--- hw/axiLiteIf.sv
interface axiLiteIf (
  input logic intf,
  input logic rstN
);

  // write address channel
  axiLitePkg::addrT AWADDR;
  axiLitePkg::protT AWPROT;
  logic AWVALID;
  logic AWREADY;
  // write data channel
  axiLitePkg::dataT WDATA;
  axiLitePkg::strbT WSTRB;
  logic WVALID;
  logic WREADY;
  // write response channel
  axiLitePkg::respT BRESP;
  logic BVALID;
  logic BREADY;
  // read address channel
  axiLitePkg::addrT ARADDR;
  axiLitePkg::protT ARPROT;
  logic ARVALID;
  logic ARREADY;
  // read data channel
  axiLitePkg::dataT RDATA;
  axiLitePkg::respT RRESP;
  logic RVALID;
  logic RREADY;

  // master drives requests and the response readies
  modport master (input intf, rstN, output AWADDR, AWPROT, AWVALID, WDATA, WSTRB, WVALID,
    BREADY, ARADDR, ARPROT, ARVALID, RREADY, input AWREADY, WREADY, BRESP, BVALID,
    ARREADY, RDATA, RRESP, RVALID);

  // slave side, as seen by the register bank
  modport slave (input intf, rstN, input AWADDR, AWPROT, AWVALID, WDATA, WSTRB, WVALID,
    BREADY, ARADDR, ARPROT, ARVALID, RREADY, output AWREADY, WREADY, BRESP, BVALID,
    ARREADY, RDATA, RRESP, RVALID);

endinterface

//--- hw/regAddrDecode.sv
module regAddrDecode #(
  parameter int unsigned NumRegs = 8
) (
  input logic intf,
  input logic rstN,
  axiLiteIf.slave bus,
  input logic wrBusy,
  input logic rdBusy,
  output axiLitePkg::wrReqT wrReq,
  output logic wrReqValid,
  output axiLitePkg::rdReqT rdReq,
  output logic rdReqValid
);

  logic wrReady;
  logic rdReady;
  logic wrAccept;
  logic rdAccept;
  axiLitePkg::addrT wrWordAddr;
  axiLitePkg::addrT rdWordAddr;

  //////////////////////////////////////////////////////////////////////
  // ready pulses
  //////////////////////////////////////////////////////////////////////

  // AW and W are taken together, so both readies share one flop
  always_ff @(posedge intf or negedge rstN) begin
    if (!rstN) begin
      wrReady <= 1'b0;
      rdReady <= 1'b0;
    end else begin
      // single-cycle pulse, held off while the response is pending
      wrReady <= !wrReady && bus.AWVALID && bus.WVALID && !wrBusy;
      rdReady <= !rdReady && bus.ARVALID && !rdBusy;
    end
  end

  assign bus.AWREADY = wrReady;
  assign bus.WREADY = wrReady;
  assign bus.ARREADY = rdReady;

  // valid stays up until transfer, so ready high means accept
  assign wrAccept = bus.AWVALID && bus.AWREADY;
  assign rdAccept = bus.ARVALID && bus.ARREADY;

  //////////////////////////////////////////////////////////////////////
  // index and range check
  //////////////////////////////////////////////////////////////////////

  // byte lane bits dropped, upper bits still count for the range
  assign wrWordAddr = bus.AWADDR >> 2;
  assign rdWordAddr = bus.ARADDR >> 2;

  // request pulses leave on the accepting edge
  always_ff @(posedge intf or negedge rstN) begin
    if (!rstN) begin
      wrReqValid <= 1'b0;
      rdReqValid <= 1'b0;
    end else begin
      wrReqValid <= wrAccept;
      rdReqValid <= rdAccept;
    end
  end

  // request payload
  always_ff @(posedge intf) begin
    if (wrAccept) begin
      wrReq.idx <= bus.AWADDR[9:2];
      wrReq.data <= bus.WDATA;
      wrReq.strb <= bus.WSTRB;
      wrReq.err <= wrWordAddr >= NumRegs;
    end
    if (rdAccept) begin
      rdReq.idx <= bus.ARADDR[9:2];
      rdReq.err <= rdWordAddr >= NumRegs;
    end
  end

  // response block must release a channel before it is reopened
  wrAcceptIdle: assert property (@(posedge intf) disable iff (!rstN) wrAccept |-> !wrBusy);
  rdAcceptIdle: assert property (@(posedge intf) disable iff (!rstN) rdAccept |-> !rdBusy);

endmodule

//--- hw/regBankExecute.sv
module regBankExecute #(
  parameter int unsigned NumRegs = 8
) (
  input logic intf,
  input logic rstN,
  input axiLitePkg::wrReqT wrReq,
  input logic wrReqValid,
  input axiLitePkg::rdReqT rdReq,
  input logic rdReqValid,
  output axiLitePkg::wrDoneT wrDone,
  output logic wrDoneValid,
  output axiLitePkg::rdDoneT rdDone,
  output logic rdDoneValid
);

  // array index width, at least one bit
  localparam int unsigned IdxW = (NumRegs > 1) ? $clog2(NumRegs) : 1;

  axiLitePkg::dataT regs [NumRegs];
  axiLitePkg::dataT wrMerged;
  logic [IdxW-1:0] wrIdx;
  logic [IdxW-1:0] rdIdx;

  // in-range requests only reach the array, so the low bits suffice
  assign wrIdx = wrReq.idx[IdxW-1:0];
  assign rdIdx = rdReq.idx[IdxW-1:0];

  //////////////////////////////////////////////////////////////////////
  // strobe merge
  //////////////////////////////////////////////////////////////////////

  // start from current contents and overlay the strobed bytes
  always_comb begin
    wrMerged = regs[wrIdx];
    for (int b = 0; b < 4; b++) begin
      if (wrReq.strb[b]) begin
        wrMerged[8*b +: 8] = wrReq.data[8*b +: 8];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // register array
  //////////////////////////////////////////////////////////////////////

  // whole bank clears on reset
  always_ff @(posedge intf or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < NumRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (wrReqValid && !wrReq.err) begin
      regs[wrIdx] <= wrMerged;
    end
  end

  // done pulses one edge after the request
  always_ff @(posedge intf or negedge rstN) begin
    if (!rstN) begin
      wrDoneValid <= 1'b0;
      rdDoneValid <= 1'b0;
    end else begin
      wrDoneValid <= wrReqValid;
      rdDoneValid <= rdReqValid;
    end
  end

  // read sees the pre-write value on a same-cycle collision
  always_ff @(posedge intf) begin
    if (wrReqValid) begin
      wrDone.err <= wrReq.err;
    end
    if (rdReqValid) begin
      rdDone.data <= rdReq.err ? '0 : regs[rdIdx];
      rdDone.err <= rdReq.err;
    end
  end

  // decode range check keeps applied writes inside the bank
  wrIdxInRange: assert property (@(posedge intf) disable iff (!rstN)
    wrReqValid && !wrReq.err |-> 32'(wrReq.idx) < NumRegs);

endmodule

//--- hw/respGenerate.sv
module respGenerate (
  input logic intf,
  input logic rstN,
  axiLiteIf.slave bus,
  input axiLitePkg::wrDoneT wrDone,
  input logic wrDoneValid,
  input axiLitePkg::rdDoneT rdDone,
  input logic rdDoneValid,
  output logic wrBusy,
  output logic rdBusy
);

  // Wait spans accept to done, Hold spans done to READY
  typedef enum logic [1:0] {
    Idle,
    Wait,
    Hold
  } chanStateT;

  chanStateT wrState;
  chanStateT rdState;
  axiLitePkg::respT bResp;
  axiLitePkg::respT rResp;
  axiLitePkg::dataT rData;

  //////////////////////////////////////////////////////////////////////
  // channel FSMs
  //////////////////////////////////////////////////////////////////////

  // accept seen straight from the bus handshake
  always_ff @(posedge intf or negedge rstN) begin
    if (!rstN) begin
      wrState <= Idle;
      rdState <= Idle;
    end else begin
      unique case (wrState)
        Idle: wrState <= (bus.AWVALID && bus.AWREADY) ? Wait : Idle;
        Wait: wrState <= wrDoneValid ? Hold : Wait;
        default: wrState <= bus.BREADY ? Idle : Hold;
      endcase
      unique case (rdState)
        Idle: rdState <= (bus.ARVALID && bus.ARREADY) ? Wait : Idle;
        Wait: rdState <= rdDoneValid ? Hold : Wait;
        default: rdState <= bus.RREADY ? Idle : Hold;
      endcase
    end
  end

  // response payload captured with done
  always_ff @(posedge intf) begin
    if (wrDoneValid) begin
      bResp <= wrDone.err ? axiLitePkg::RespSlvErr : axiLitePkg::RespOkay;
    end
    if (rdDoneValid) begin
      rResp <= rdDone.err ? axiLitePkg::RespSlvErr : axiLitePkg::RespOkay;
      rData <= rdDone.data;
    end
  end

  assign wrBusy = wrState != Idle;
  assign rdBusy = rdState != Idle;
  assign bus.BVALID = wrState == Hold;
  assign bus.BRESP = bResp;
  assign bus.RVALID = rdState == Hold;
  assign bus.RRESP = rResp;
  assign bus.RDATA = rData;

  // held responses stay put until the master takes them
  bHeld: assert property (@(posedge intf) disable iff (!rstN)
    bus.BVALID && !bus.BREADY |=> bus.BVALID && $stable(bus.BRESP));
  rHeld: assert property (@(posedge intf) disable iff (!rstN)
    bus.RVALID && !bus.RREADY |=> bus.RVALID && $stable(bus.RRESP) && $stable(bus.RDATA));

endmodule

//--- hw/axiLiteRegBank.sv
module axiLiteRegBank #(
  parameter int unsigned NumRegs = 8
) (
  input logic intf,
  input logic rstN,
  axiLiteIf.slave bus
);

  // decode to execute
  axiLitePkg::wrReqT wrReq;
  logic wrReqValid;
  axiLitePkg::rdReqT rdReq;
  logic rdReqValid;
  // execute to result
  axiLitePkg::wrDoneT wrDone;
  logic wrDoneValid;
  axiLitePkg::rdDoneT rdDone;
  logic rdDoneValid;
  // result back to decode
  logic wrBusy;
  logic rdBusy;

  //////////////////////////////////////////////////////////////////////
  // decode, execute, result chain
  //////////////////////////////////////////////////////////////////////

  regAddrDecode #(.NumRegs(NumRegs)) u_regAddrDecode (.intf(intf), .rstN(rstN), .bus(bus),
    .wrBusy(wrBusy), .rdBusy(rdBusy), .wrReq(wrReq), .wrReqValid(wrReqValid),
    .rdReq(rdReq), .rdReqValid(rdReqValid));

  regBankExecute #(.NumRegs(NumRegs)) u_regBankExecute (.intf(intf), .rstN(rstN),
    .wrReq(wrReq), .wrReqValid(wrReqValid), .rdReq(rdReq), .rdReqValid(rdReqValid),
    .wrDone(wrDone), .wrDoneValid(wrDoneValid), .rdDone(rdDone), .rdDoneValid(rdDoneValid));

  respGenerate u_respGenerate (.intf(intf), .rstN(rstN), .bus(bus), .wrDone(wrDone),
    .wrDoneValid(wrDoneValid), .rdDone(rdDone), .rdDoneValid(rdDoneValid),
    .wrBusy(wrBusy), .rdBusy(rdBusy));

endmodule

//--- verification/axiLiteMaster.sv
module axiLiteMaster (
  axiLiteIf.master bus
);

  timeunit 1ns;
  timeprecision 100ps;

  //////////////////////////////////////////////////////////////////////
  // bus setup
  //////////////////////////////////////////////////////////////////////

  // all master outputs quiet before the first edge
  task automatic initBus();
    bus.AWADDR <= '0;
    bus.AWPROT <= '0;
    bus.AWVALID <= 1'b0;
    bus.WDATA <= '0;
    bus.WSTRB <= '0;
    bus.WVALID <= 1'b0;
    bus.BREADY <= 1'b0;
    bus.ARADDR <= '0;
    bus.ARPROT <= '0;
    bus.ARVALID <= 1'b0;
    bus.RREADY <= 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // channel tasks
  //////////////////////////////////////////////////////////////////////

  // AW and W raised together, then B taken after a random stall
  task automatic writeTxn(input axiLitePkg::addrT addr, input axiLitePkg::dataT data,
    input axiLitePkg::strbT strb, output axiLitePkg::respT resp);
    repeat ($urandom_range(3)) @(posedge bus.intf);
    @(posedge bus.intf);
    bus.AWADDR <= addr;
    bus.AWPROT <= 3'b000;
    bus.AWVALID <= 1'b1;
    bus.WDATA <= data;
    bus.WSTRB <= strb;
    bus.WVALID <= 1'b1;
    // ready seen at an edge means the pair went across on it
    do begin
      @(posedge bus.intf);
    end while (!bus.AWREADY);
    bus.AWVALID <= 1'b0;
    bus.WVALID <= 1'b0;
    // back-pressure on B
    repeat ($urandom_range(3)) @(posedge bus.intf);
    bus.BREADY <= 1'b1;
    do begin
      @(posedge bus.intf);
    end while (!bus.BVALID);
    resp = bus.BRESP;
    bus.BREADY <= 1'b0;
  endtask

  // AR raised, then R taken after a random stall
  task automatic readTxn(input axiLitePkg::addrT addr, output axiLitePkg::dataT data,
    output axiLitePkg::respT resp);
    repeat ($urandom_range(3)) @(posedge bus.intf);
    @(posedge bus.intf);
    bus.ARADDR <= addr;
    bus.ARPROT <= 3'b000;
    bus.ARVALID <= 1'b1;
    do begin
      @(posedge bus.intf);
    end while (!bus.ARREADY);
    bus.ARVALID <= 1'b0;
    // back-pressure on R
    repeat ($urandom_range(3)) @(posedge bus.intf);
    bus.RREADY <= 1'b1;
    do begin
      @(posedge bus.intf);
    end while (!bus.RVALID);
    data = bus.RDATA;
    resp = bus.RRESP;
    bus.RREADY <= 1'b0;
  endtask

endmodule

//--- verification/axiLiteRegBankTb.sv
module axiLiteRegBankTb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NumRegs = 8;
  localparam int IdxW = $clog2(NumRegs);
  localparam int ClkPeriod = 4;
  localparam int ResetCycles = 16;
  // reads, full pairs, partial pairs, range triples, random mix
  localparam int NumTxns = 8 + 16 + 24 + 18 + 200;
  // past the bank, incl. upper bits that alias index 0
  localparam axiLitePkg::addrT BadAddrs [6] = '{32'h20, 32'h24, 32'h3c, 32'h400, 32'h41c,
    32'hffff_fffc};

  logic intf;
  logic rstN;
  string testName = "reset";
  // shadow of the bank contents
  axiLitePkg::dataT shadow [NumRegs] = '{default: '0};
  // expected responses, in accept order
  axiLitePkg::respT expWr [$];
  axiLitePkg::respT expRdResp [$];
  axiLitePkg::dataT expRdData [$];
  int wrIssued = 0;
  int rdIssued = 0;
  int wrSeen = 0;
  int rdSeen = 0;

  axiLiteIf bus (.intf(intf), .rstN(rstN));
  axiLiteRegBank #(.NumRegs(NumRegs)) u_axiLiteRegBank (.intf(intf), .rstN(rstN), .bus(bus));
  axiLiteMaster u_axiLiteMaster (.bus(bus));

  initial begin
    intf = 1'b0;
    forever #(ClkPeriod / 2) intf = ~intf;
  end

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // byte lanes ignored, whole word address range checked
  function automatic axiLitePkg::respT refWrite(axiLitePkg::addrT addr,
    axiLitePkg::dataT data, axiLitePkg::strbT strb);
    axiLitePkg::addrT word;
    word = addr >> 2;
    if (word >= NumRegs) begin
      return axiLitePkg::RespSlvErr;
    end
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        shadow[word[IdxW-1:0]][8*b +: 8] = data[8*b +: 8];
      end
    end
    return axiLitePkg::RespOkay;
  endfunction

  // out of range reads give zero data
  function automatic axiLitePkg::respT refRead(axiLitePkg::addrT addr,
    output axiLitePkg::dataT data);
    axiLitePkg::addrT word;
    word = addr >> 2;
    data = '0;
    if (word >= NumRegs) begin
      return axiLitePkg::RespSlvErr;
    end
    data = shadow[word[IdxW-1:0]];
    return axiLitePkg::RespOkay;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  task automatic stopRun(string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic checkResp(axiLitePkg::respT exp, axiLitePkg::respT act);
    if (act !== exp) begin
      stopRun($sformatf("Fail %s resp expected %0d actual %0d", testName, exp, act));
    end
  endtask

  task automatic checkData(axiLitePkg::dataT exp, axiLitePkg::dataT act);
    if (act !== exp) begin
      stopRun($sformatf("Fail %s data expected %h actual %h", testName, exp, act));
    end
  endtask

  // expectations made at accept, compared at response
  always @(posedge intf) begin : compareResponses
    axiLitePkg::dataT expData;
    axiLitePkg::respT expResp;
    if (rstN) begin
      // AW and W share one ready pulse
      if (bus.AWREADY !== bus.WREADY) begin
        stopRun("AWREADY and WREADY did not pulse together");
      end
      // read first, a same-edge read sees the old word
      if (bus.ARVALID && bus.ARREADY) begin
        expResp = refRead(bus.ARADDR, expData);
        expRdResp.push_back(expResp);
        expRdData.push_back(expData);
      end
      if (bus.AWVALID && bus.AWREADY) begin
        expWr.push_back(refWrite(bus.AWADDR, bus.WDATA, bus.WSTRB));
      end
      // a held response needs a transaction behind it
      if (bus.BVALID && expWr.size() == 0) begin
        stopRun("write response raised with no write outstanding");
      end else if (bus.BVALID && bus.BREADY) begin
        wrSeen++;
        checkResp(expWr.pop_front(), bus.BRESP);
      end
      if (bus.RVALID && expRdResp.size() == 0) begin
        stopRun("read response raised with no read outstanding");
      end else if (bus.RVALID && bus.RREADY) begin
        rdSeen++;
        checkResp(expRdResp.pop_front(), bus.RRESP);
        checkData(expRdData.pop_front(), bus.RDATA);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic doWrite(axiLitePkg::addrT addr, axiLitePkg::dataT data,
    axiLitePkg::strbT strb);
    axiLitePkg::respT resp;
    wrIssued++;
    u_axiLiteMaster.writeTxn(addr, data, strb, resp);
  endtask

  task automatic doRead(axiLitePkg::addrT addr, output axiLitePkg::dataT data);
    axiLitePkg::respT resp;
    rdIssued++;
    u_axiLiteMaster.readTxn(addr, data, resp);
  endtask

  // words 0 to 11 with junk in the byte lane bits
  function automatic axiLitePkg::addrT randomAddr();
    return axiLitePkg::addrT'($urandom_range(11) * 4 + $urandom_range(3));
  endfunction

  initial begin : runTests
    axiLitePkg::dataT data;
    axiLitePkg::dataT value;
    void'($urandom(32'h0ab6_77a1));
    rstN <= 1'b0;
    u_axiLiteMaster.initBus();
    repeat (ResetCycles) @(posedge intf);
    rstN <= 1'b1;
    @(posedge intf);

    testName = "resetValues";
    for (int i = 0; i < NumRegs; i++) begin
      doRead(axiLitePkg::addrT'(4 * i), data);
    end

    // written value read straight back
    testName = "fullStrobe";
    for (int i = 0; i < NumRegs; i++) begin
      value = $urandom;
      doWrite(axiLitePkg::addrT'(4 * i), value, 4'hf);
      doRead(axiLitePkg::addrT'(4 * i), data);
      checkData(value, data);
    end

    // strobe patterns 0 to 11, none full
    testName = "partialStrobe";
    for (int i = 0; i < 12; i++) begin
      doWrite(axiLitePkg::addrT'(4 * (i % NumRegs)), $urandom, axiLitePkg::strbT'(i));
      doRead(axiLitePkg::addrT'(4 * (i % NumRegs)), data);
    end

    // then the aliased in-range word must be untouched
    testName = "outOfRange";
    for (int i = 0; i < 6; i++) begin
      doWrite(BadAddrs[i], $urandom, 4'hf);
      doRead(BadAddrs[i], data);
      doRead(axiLitePkg::addrT'(((BadAddrs[i] >> 2) % NumRegs) * 4), data);
    end

    // both channels busy at once
    testName = "randomMixed";
    fork
      for (int i = 0; i < 100; i++) begin
        doWrite(randomAddr(), $urandom, axiLitePkg::strbT'($urandom_range(15)));
      end
      for (int i = 0; i < 100; i++) begin
        doRead(randomAddr(), data);
      end
    join

    // one more edge so the last transfer is counted
    @(posedge intf);
    if (wrSeen != wrIssued || rdSeen != rdIssued || expWr.size() != 0
        || expRdResp.size() != 0) begin
      $display("responses lost or duplicated, %0d of %0d writes and %0d of %0d reads answered",
        wrSeen, wrIssued, rdSeen, rdIssued);
      $display("** FAIL **");
      $fatal(1);
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

  // 16 cycles per transaction is ample
  initial begin : watchdog
    #((NumTxns * 16 + ResetCycles) * ClkPeriod);
    $display("run hung, no end after %0d cycles", NumTxns * 16 + ResetCycles);
    $display("** FAIL **");
    $fatal(1);
  end

endmodule

//--- axiLiteRegBank.f
hw/axiLitePkg.sv
hw/axiLiteIf.sv
hw/regAddrDecode.sv
hw/regBankExecute.sv
hw/respGenerate.sv
hw/axiLiteRegBank.sv
verification/axiLiteMaster.sv
verification/axiLiteRegBankTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= axiLiteRegBankTb
FLIST ?= axiLiteRegBank.f
EXTRA_FLAGS ?=

.PHONY: sim clean

# build the model, run it, and look for the pass line in its output
sim:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) -f $(FLIST) $(EXTRA_FLAGS)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qxF '** PASS **'

clean:
	rm -rf obj_dir
